//--- hw/smc_lite_pkg.sv
// Shared widths, queue depth and phase encoding for the static memory
// controller and its testbench. Referenced by scoped names only.

package smc_lite_pkg;

   // --------------------
   // External bus widths
   // --------------------
   localparam int unsigned SMC_ADDR_W = 16;  // External address
   localparam int unsigned SMC_DATA_W = 32;  // Read and write data
   localparam int unsigned SMC_BE_W   = 4;   // One byte strobe per byte lane

   // --------------------
   // Access timing fields
   // --------------------
   localparam int unsigned SMC_LE_W = 2;  // Leading-edge delay, 0 to 3 cycles
   localparam int unsigned SMC_WS_W = 8;  // Wait states, 0 to 255

   // --------------------
   // Request queue
   // --------------------
   // Entries in the queue, and also the host's starting credit count
   localparam int unsigned SMC_QUEUE_DEPTH = 2;
   localparam int unsigned SMC_PTR_W = (SMC_QUEUE_DEPTH > 1) ? $clog2(SMC_QUEUE_DEPTH) : 1;
   localparam int unsigned SMC_CNT_W = $clog2(SMC_QUEUE_DEPTH + 1);  // Fill count 0..depth

   // Access phases
   typedef enum logic [1:0] {
      IDLE  = 2'b00,  // No access in progress
      LE    = 2'b01,  // Chip select low, strobe still high
      RW    = 2'b10,  // Strobe active
      FLOAT = 2'b11   // Turnaround, bus released
   } smc_phase_t;

endpackage

//--- hw/smc_access_queue.sv
// Request queue between the host port and the phase controller.
// Accepts one access per req_valid and presents the oldest one at the head.
`timescale 1ns/10ps

module smc_access_queue (
   input  logic                                sys_clk15,
   input  logic                                n_sys_reset15,
   input  logic                                req_valid,   // Host push, credit already spent
   input  logic                                req_write,
   input  logic [smc_lite_pkg::SMC_ADDR_W-1:0] req_addr,
   input  logic [smc_lite_pkg::SMC_DATA_W-1:0] req_wdata,
   input  logic [smc_lite_pkg::SMC_BE_W-1:0]   req_n_be,
   input  logic [smc_lite_pkg::SMC_LE_W-1:0]   req_wele,
   input  logic [smc_lite_pkg::SMC_WS_W-1:0]   req_ws,
   input  logic                                q_pop,       // Controller takes the head
   output logic                                q_valid,
   output logic                                q_write,
   output logic [smc_lite_pkg::SMC_ADDR_W-1:0] q_addr,
   output logic [smc_lite_pkg::SMC_DATA_W-1:0] q_wdata,
   output logic [smc_lite_pkg::SMC_BE_W-1:0]   q_n_be,
   output logic [smc_lite_pkg::SMC_LE_W-1:0]   q_wele,
   output logic [smc_lite_pkg::SMC_WS_W-1:0]   q_ws
);

   // Entry storage
   logic                                write_mem [smc_lite_pkg::SMC_QUEUE_DEPTH];
   logic [smc_lite_pkg::SMC_ADDR_W-1:0] addr_mem  [smc_lite_pkg::SMC_QUEUE_DEPTH];
   logic [smc_lite_pkg::SMC_DATA_W-1:0] wdata_mem [smc_lite_pkg::SMC_QUEUE_DEPTH];
   logic [smc_lite_pkg::SMC_BE_W-1:0]   n_be_mem  [smc_lite_pkg::SMC_QUEUE_DEPTH];
   logic [smc_lite_pkg::SMC_LE_W-1:0]   wele_mem  [smc_lite_pkg::SMC_QUEUE_DEPTH];
   logic [smc_lite_pkg::SMC_WS_W-1:0]   ws_mem    [smc_lite_pkg::SMC_QUEUE_DEPTH];

   logic [smc_lite_pkg::SMC_PTR_W-1:0] wr_ptr;
   logic [smc_lite_pkg::SMC_PTR_W-1:0] rd_ptr;
   logic [smc_lite_pkg::SMC_CNT_W-1:0] count;   // Entries held

   // Pointer advance with wrap at the last entry
   function automatic logic [smc_lite_pkg::SMC_PTR_W-1:0] ptr_inc(
      input logic [smc_lite_pkg::SMC_PTR_W-1:0] ptr
   );
      if (ptr == smc_lite_pkg::SMC_PTR_W'(smc_lite_pkg::SMC_QUEUE_DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (req_valid)
            wr_ptr <= ptr_inc(wr_ptr);
         if (q_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         if (req_valid && !q_pop)
            count <= count + 1'b1;
         else if (!req_valid && q_pop)
            count <= count - 1'b1;  // Push and pop together leave it
      end
   end

   // Payload write
   always_ff @(posedge sys_clk15)
   begin
      if (req_valid)
      begin
         write_mem[wr_ptr] <= req_write;
         addr_mem[wr_ptr]  <= req_addr;
         wdata_mem[wr_ptr] <= req_wdata;
         n_be_mem[wr_ptr]  <= req_n_be;
         wele_mem[wr_ptr]  <= req_wele;
         ws_mem[wr_ptr]    <= req_ws;
      end
   end

   // Head of queue
   assign q_valid = (count != '0);
   assign q_write = write_mem[rd_ptr];
   assign q_addr  = addr_mem[rd_ptr];
   assign q_wdata = wdata_mem[rd_ptr];
   assign q_n_be  = n_be_mem[rd_ptr];
   assign q_wele  = wele_mem[rd_ptr];
   assign q_ws    = ws_mem[rd_ptr];

endmodule

//--- hw/smc_phase_ctrl.sv
// Access state machine. Steps each queued access through IDLE, LE, RW and
// FLOAT, popping the queue head as an access starts.
`timescale 1ns/10ps

module smc_phase_ctrl (
   input  logic                              sys_clk15,
   input  logic                              n_sys_reset15,
   input  logic                              q_valid,     // Queue holds an access
   input  logic                              le_done,     // Last LE cycle
   input  logic                              ws_done,     // Last RW cycle
   input  logic [smc_lite_pkg::SMC_LE_W-1:0] q_wele,      // Head's leading-edge delay
   output logic                              q_pop,
   output smc_lite_pkg::smc_phase_t          cur_phase,
   output smc_lite_pkg::smc_phase_t          next_phase
);

   logic can_start;        // Free to take a new access this cycle
   smc_lite_pkg::smc_phase_t start_phase;   // First phase of the head access

   // --------------------
   // Start of an access
   // --------------------
   assign can_start = (cur_phase == smc_lite_pkg::IDLE) ||
                      (cur_phase == smc_lite_pkg::FLOAT);
   assign q_pop     = can_start && q_valid;

   // LE skipped entirely for zero delay
   assign start_phase = (q_wele != '0) ? smc_lite_pkg::LE : smc_lite_pkg::RW;

   // --------------------
   // Next state
   // --------------------
   always_comb
   begin
      next_phase = cur_phase;   // Hold by default
      case (cur_phase)
         smc_lite_pkg::IDLE:
         begin
            if (q_valid)
               next_phase = start_phase;
         end
         smc_lite_pkg::LE:
         begin
            if (le_done)
               next_phase = smc_lite_pkg::RW;
         end
         smc_lite_pkg::RW:
         begin
            if (ws_done)
               next_phase = smc_lite_pkg::FLOAT;
         end
         smc_lite_pkg::FLOAT:
         begin
            // Chain straight into the next access, else go quiet
            if (q_valid)
               next_phase = start_phase;
            else
               next_phase = smc_lite_pkg::IDLE;
         end
         default:
            next_phase = smc_lite_pkg::IDLE;
      endcase
   end

   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
         cur_phase <= smc_lite_pkg::IDLE;
      else
         cur_phase <= next_phase;
   end

endmodule

//--- hw/smc_edge_timer.sv
// Leading-edge and wait-state counters for the access in progress.
// Loaded on pop, flags the final cycle of LE and of RW.
`timescale 1ns/10ps

module smc_edge_timer (
   input  logic                              sys_clk15,
   input  logic                              n_sys_reset15,
   input  logic                              q_pop,        // Load from queue head
   input  logic [smc_lite_pkg::SMC_LE_W-1:0] q_wele,
   input  logic [smc_lite_pkg::SMC_WS_W-1:0] q_ws,
   input  smc_lite_pkg::smc_phase_t          next_phase,
   output logic                              le_done,
   output logic                              ws_done
);

   logic [smc_lite_pkg::SMC_LE_W-1:0] le_cnt;  // LE cycles left, incl. current
   logic [smc_lite_pkg::SMC_WS_W-1:0] ws_cnt;  // RW cycles left after current
   logic                              in_le;   // Phase now is LE
   logic                              in_rw;   // Phase now is RW

   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         le_cnt <= '0;
         ws_cnt <= '0;
         in_le  <= 1'b0;
         in_rw  <= 1'b0;
      end
      else
      begin
         in_le <= (next_phase == smc_lite_pkg::LE);
         in_rw <= (next_phase == smc_lite_pkg::RW);
         if (q_pop)
         begin
            le_cnt <= q_wele;
            ws_cnt <= q_ws;
         end
         else
         begin
            if (in_le && next_phase == smc_lite_pkg::LE)
               le_cnt <= le_cnt - 1'b1;   // Staying in LE
            if (in_rw && next_phase == smc_lite_pkg::RW)
               ws_cnt <= ws_cnt - 1'b1;   // LE to RW edge does not count
         end
      end
   end

   // Final cycle flags
   assign le_done = in_le && (le_cnt == smc_lite_pkg::SMC_LE_W'(1));
   assign ws_done = in_rw && (ws_cnt == '0);

endmodule

//--- hw/smc_ext_bus.sv
// External bus driver. Holds the current access and registers chip select,
// strobes, byte enables and driver enable from the next phase.
`timescale 1ns/10ps

module smc_ext_bus (
   input  logic                                sys_clk15,
   input  logic                                n_sys_reset15,
   input  logic                                q_pop,       // New access starts
   input  logic                                q_write,
   input  logic [smc_lite_pkg::SMC_ADDR_W-1:0] q_addr,
   input  logic [smc_lite_pkg::SMC_DATA_W-1:0] q_wdata,
   input  logic [smc_lite_pkg::SMC_BE_W-1:0]   q_n_be,
   input  smc_lite_pkg::smc_phase_t            next_phase,
   output logic [smc_lite_pkg::SMC_ADDR_W-1:0] smc_addr,
   output logic [smc_lite_pkg::SMC_DATA_W-1:0] smc_wdata,
   output logic                                smc_n_cs,     // Chip select, active low
   output logic                                smc_n_rd,     // Read strobe, active low
   output logic [smc_lite_pkg::SMC_BE_W-1:0]   smc_n_we,     // Byte write enables
   output logic                                smc_n_wr,     // Write strobe, active low
   output logic                                smc_n_ext_oe, // External driver enable
   output logic                                smc_busy
);

   logic                              cur_write;  // Direction of current access
   logic [smc_lite_pkg::SMC_BE_W-1:0] cur_n_be;
   logic                              sel_write;  // Direction for the coming cycle
   logic [smc_lite_pkg::SMC_BE_W-1:0] sel_n_be;
   logic                              cs_on;      // LE or RW next
   logic                              strobe_on;  // RW next

   // --------------------
   // Current access
   // --------------------
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
         cur_write <= 1'b0;
      else if (q_pop)
         cur_write <= q_write;
   end

   // Address and data held for the whole access
   always_ff @(posedge sys_clk15)
   begin
      if (q_pop)
      begin
         smc_addr  <= q_addr;
         smc_wdata <= q_wdata;
         cur_n_be  <= q_n_be;
      end
   end

   // On the pop edge the head is the access being started
   assign sel_write = q_pop ? q_write : cur_write;
   assign sel_n_be  = q_pop ? q_n_be  : cur_n_be;

   assign cs_on     = (next_phase == smc_lite_pkg::LE) || (next_phase == smc_lite_pkg::RW);
   assign strobe_on = (next_phase == smc_lite_pkg::RW);

   // --------------------
   // Registered strobes
   // --------------------
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         smc_n_cs     <= 1'b1;
         smc_n_rd     <= 1'b1;
         smc_n_we     <= '1;
         smc_n_wr     <= 1'b1;
         smc_n_ext_oe <= 1'b1;
         smc_busy     <= 1'b0;
      end
      else
      begin
         smc_n_cs     <= !cs_on;
         smc_n_rd     <= !(strobe_on && !sel_write);
         smc_n_wr     <= !(strobe_on && sel_write);
         smc_n_we     <= (strobe_on && sel_write) ? sel_n_be : '1;
         smc_n_ext_oe <= !(cs_on && sel_write);   // Drive data through LE and RW
         smc_busy     <= (next_phase != smc_lite_pkg::IDLE);
      end
   end

endmodule

//--- hw/smc_read_return.sv
// Host return path. Captures read data on the last RW edge and pulses
// rdata_valid and credit_return through the FLOAT cycle.
`timescale 1ns/10ps

module smc_read_return (
   input  logic                                sys_clk15,
   input  logic                                n_sys_reset15,
   input  smc_lite_pkg::smc_phase_t            cur_phase,
   input  smc_lite_pkg::smc_phase_t            next_phase,
   input  logic                                smc_n_rd,    // Low only in a read's RW
   input  logic [smc_lite_pkg::SMC_DATA_W-1:0] smc_rdata,
   output logic [smc_lite_pkg::SMC_DATA_W-1:0] rdata,
   output logic                                rdata_valid,
   output logic                                credit_return
);

   logic rw_end;   // Edge closing the last RW cycle
   logic rd_end;   // Same, for a read

   assign rw_end = (cur_phase == smc_lite_pkg::RW) && (next_phase == smc_lite_pkg::FLOAT);
   assign rd_end = rw_end && !smc_n_rd;

   // Data capture
   always_ff @(posedge sys_clk15)
   begin
      if (rd_end)
         rdata <= smc_rdata;
   end

   // One pulse each per completed access
   always_ff @(posedge sys_clk15 or negedge n_sys_reset15)
   begin
      if (!n_sys_reset15)
      begin
         rdata_valid   <= 1'b0;
         credit_return <= 1'b0;
      end
      else
      begin
         rdata_valid   <= rd_end;
         credit_return <= rw_end;   // Writes return credit too
      end
   end

endmodule

//--- hw/smc_lite_top.sv
// Static memory controller top level. Host request port with credit return
// on one side, external SRAM-style bus on the other.
`timescale 1ns/10ps

module smc_lite_top (
   input  logic                                sys_clk15,
   input  logic                                n_sys_reset15,
   // Host side
   input  logic                                req_valid,
   input  logic                                req_write,
   input  logic [smc_lite_pkg::SMC_ADDR_W-1:0] req_addr,
   input  logic [smc_lite_pkg::SMC_DATA_W-1:0] req_wdata,
   input  logic [smc_lite_pkg::SMC_BE_W-1:0]   req_n_be,
   input  logic [smc_lite_pkg::SMC_LE_W-1:0]   req_wele,
   input  logic [smc_lite_pkg::SMC_WS_W-1:0]   req_ws,
   output logic                                credit_return,
   output logic                                rdata_valid,
   output logic [smc_lite_pkg::SMC_DATA_W-1:0] rdata,
   output logic                                smc_busy,
   // External bus
   output logic [smc_lite_pkg::SMC_ADDR_W-1:0] smc_addr,
   output logic [smc_lite_pkg::SMC_DATA_W-1:0] smc_wdata,
   output logic                                smc_n_cs,
   output logic                                smc_n_rd,
   output logic [smc_lite_pkg::SMC_BE_W-1:0]   smc_n_we,
   output logic                                smc_n_wr,
   output logic                                smc_n_ext_oe,
   input  logic [smc_lite_pkg::SMC_DATA_W-1:0] smc_rdata
);

   // Queue head
   logic                                q_valid;
   logic                                q_write;
   logic [smc_lite_pkg::SMC_ADDR_W-1:0] q_addr;
   logic [smc_lite_pkg::SMC_DATA_W-1:0] q_wdata;
   logic [smc_lite_pkg::SMC_BE_W-1:0]   q_n_be;
   logic [smc_lite_pkg::SMC_LE_W-1:0]   q_wele;
   logic [smc_lite_pkg::SMC_WS_W-1:0]   q_ws;
   // Control
   logic                     q_pop;
   logic                     le_done;
   logic                     ws_done;
   smc_lite_pkg::smc_phase_t cur_phase;
   smc_lite_pkg::smc_phase_t next_phase;

   smc_access_queue i_queue (
      .sys_clk15, .n_sys_reset15,
      .req_valid, .req_write, .req_addr, .req_wdata, .req_n_be, .req_wele, .req_ws,
      .q_pop,
      .q_valid, .q_write, .q_addr, .q_wdata, .q_n_be, .q_wele, .q_ws
   );

   smc_phase_ctrl i_ctrl (
      .sys_clk15, .n_sys_reset15,
      .q_valid, .le_done, .ws_done, .q_wele,
      .q_pop, .cur_phase, .next_phase
   );

   smc_edge_timer i_timer (
      .sys_clk15, .n_sys_reset15,
      .q_pop, .q_wele, .q_ws, .next_phase,
      .le_done, .ws_done
   );

   smc_ext_bus i_bus (
      .sys_clk15, .n_sys_reset15,
      .q_pop, .q_write, .q_addr, .q_wdata, .q_n_be, .next_phase,
      .smc_addr, .smc_wdata, .smc_n_cs, .smc_n_rd, .smc_n_we, .smc_n_wr,
      .smc_n_ext_oe, .smc_busy
   );

   // Read strobe fed back to tell reads from writes at RW end
   smc_read_return i_return (
      .sys_clk15, .n_sys_reset15,
      .cur_phase, .next_phase, .smc_n_rd, .smc_rdata,
      .rdata, .rdata_valid, .credit_return
   );

endmodule

//--- testbench/smc_lite_assert.sv
// Concurrent checks on the host handshake and the bus strobes.
// Bound into the controller top level.
`timescale 1ns/10ps

module smc_lite_assert (
   input logic                               sys_clk15,
   input logic                               n_sys_reset15,
   input logic                               req_valid,
   input logic [smc_lite_pkg::SMC_CNT_W-1:0] q_count,     // Queue fill level
   input logic                               smc_n_cs,
   input logic                               smc_n_rd,
   input logic                               smc_n_wr,
   input logic                               credit_return,
   input smc_lite_pkg::smc_phase_t           cur_phase
);

   int unsigned fail_count = 0;   // Failed assertions so far

   a_no_push_full: assert property (@(posedge sys_clk15) disable iff (!n_sys_reset15)
      req_valid |-> (q_count < smc_lite_pkg::SMC_QUEUE_DEPTH))
   else
   begin
      $error("req_valid while request queue full");
      fail_count++;
   end

   a_rd_wr_excl: assert property (@(posedge sys_clk15) disable iff (!n_sys_reset15)
      smc_n_rd || smc_n_wr)
   else
   begin
      $error("smc_n_rd and smc_n_wr low together");
      fail_count++;
   end

   a_strobe_in_cs: assert property (@(posedge sys_clk15) disable iff (!n_sys_reset15)
      (!smc_n_rd || !smc_n_wr) |-> !smc_n_cs)
   else
   begin
      $error("Strobe low outside chip select");
      fail_count++;
   end

   a_credit_float: assert property (@(posedge sys_clk15) disable iff (!n_sys_reset15)
      credit_return |-> (cur_phase == smc_lite_pkg::FLOAT))
   else
   begin
      $error("credit_return outside FLOAT");
      fail_count++;
   end

endmodule

bind smc_lite_top smc_lite_assert i_assert (
   .sys_clk15,
   .n_sys_reset15,
   .req_valid,
   .q_count (i_queue.count),
   .smc_n_cs,
   .smc_n_rd,
   .smc_n_wr,
   .credit_return,
   .cur_phase
);

//--- testbench/smc_lite_checks.svh
// Compare tasks for the controller testbench, sized from the package
// widths. Included inside the testbench module.
`ifndef SMC_LITE_CHECKS_SVH
`define SMC_LITE_CHECKS_SVH

// Read data and write data words
task automatic check_data(input string name,
                          input logic [smc_lite_pkg::SMC_DATA_W-1:0] got,
                          input logic [smc_lite_pkg::SMC_DATA_W-1:0] exp);
   if (got !== exp)
   begin
      $display("MISMATCH time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
      abort_run("Data word differs from the expected value");
   end
endtask

// External address
task automatic check_addr(input string name,
                          input logic [smc_lite_pkg::SMC_ADDR_W-1:0] got,
                          input logic [smc_lite_pkg::SMC_ADDR_W-1:0] exp);
   if (got !== exp)
   begin
      $display("MISMATCH time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
      abort_run("Bus address differs from the request");
   end
endtask

// Byte write enables
task automatic check_be(input string name,
                        input logic [smc_lite_pkg::SMC_BE_W-1:0] got,
                        input logic [smc_lite_pkg::SMC_BE_W-1:0] exp);
   if (got !== exp)
   begin
      $display("MISMATCH time=%0t signal=%s got=%b exp=%b", $time, name, got, exp);
      abort_run("Byte enables differ from the request");
   end
endtask

// Single strobe or flag level
task automatic check_level(input string name, input logic got, input logic exp);
   if (got !== exp)
   begin
      $display("MISMATCH time=%0t signal=%s got=%b exp=%b", $time, name, got, exp);
      abort_run("Strobe or flag at the wrong level");
   end
endtask

// Phase widths in cycles, one bit wider than the wait-state field
task automatic check_width(input string name,
                           input logic [smc_lite_pkg::SMC_WS_W:0] got,
                           input logic [smc_lite_pkg::SMC_WS_W:0] exp);
   if (got !== exp)
   begin
      $display("MISMATCH time=%0t signal=%s got=%0d exp=%0d", $time, name, got, exp);
      abort_run("Phase lasted the wrong number of cycles");
   end
endtask

// Credit and completion counts
task automatic check_count(input string name, input int got, input int exp);
   if (got != exp)
   begin
      $display("MISMATCH time=%0t signal=%s got=%0d exp=%0d", $time, name, got, exp);
      abort_run("Credit or completion count is wrong");
   end
endtask

`endif

//--- testbench/smc_lite_tb.sv
// Testbench for the static memory controller. Replays the golden access list
// with random gaps under credit flow control and checks every bus strobe.
`timescale 1ns/10ps

module smc_lite_tb;

   localparam int NUM_ACC = 16;   // Rows in the golden file
   localparam int NUM_COL = 7;    // Words per row
   localparam int DEPTH   = smc_lite_pkg::SMC_QUEUE_DEPTH;

   logic                                sys_clk15;
   logic                                n_sys_reset15;
   logic                                req_valid;
   logic                                req_write;
   logic [smc_lite_pkg::SMC_ADDR_W-1:0] req_addr;
   logic [smc_lite_pkg::SMC_DATA_W-1:0] req_wdata;
   logic [smc_lite_pkg::SMC_BE_W-1:0]   req_n_be;
   logic [smc_lite_pkg::SMC_LE_W-1:0]   req_wele;
   logic [smc_lite_pkg::SMC_WS_W-1:0]   req_ws;
   logic                                credit_return;
   logic                                rdata_valid;
   logic [smc_lite_pkg::SMC_DATA_W-1:0] rdata;
   logic                                smc_busy;
   logic [smc_lite_pkg::SMC_ADDR_W-1:0] smc_addr;
   logic [smc_lite_pkg::SMC_DATA_W-1:0] smc_wdata;
   logic                                smc_n_cs;
   logic                                smc_n_rd;
   logic [smc_lite_pkg::SMC_BE_W-1:0]   smc_n_we;
   logic                                smc_n_wr;
   logic                                smc_n_ext_oe;
   logic [smc_lite_pkg::SMC_DATA_W-1:0] smc_rdata;

   // Golden rows, raw and unpacked
   logic [31:0]                         golden_mem [NUM_ACC*NUM_COL];
   logic                                acc_write  [NUM_ACC];
   logic [smc_lite_pkg::SMC_ADDR_W-1:0] acc_addr   [NUM_ACC];
   logic [smc_lite_pkg::SMC_BE_W-1:0]   acc_n_be   [NUM_ACC];
   logic [smc_lite_pkg::SMC_DATA_W-1:0] acc_wdata  [NUM_ACC];
   logic [smc_lite_pkg::SMC_LE_W-1:0]   acc_wele   [NUM_ACC];
   logic [smc_lite_pkg::SMC_WS_W-1:0]   acc_ws     [NUM_ACC];
   logic [smc_lite_pkg::SMC_DATA_W-1:0] acc_rdata  [NUM_ACC];
   logic [smc_lite_pkg::SMC_DATA_W-1:0] sram [2**smc_lite_pkg::SMC_ADDR_W];  // SRAM model

   int          credits;                       // Host credits in hand
   int          issued, accepted, started;     // Requests driven, taken, begun on bus
   int          mon_idx, ret_idx;              // Access on bus, access completing
   int          reads_done, num_reads;
   int unsigned cycle_count, timeout_limit;
   logic        prev_cs, expect_chain;
   logic [smc_lite_pkg::SMC_WS_W:0] lead_cnt, strobe_cnt;
   logic [31:0] rand_state;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   `include "smc_lite_checks.svh"

   // LCG for idle gaps
   function automatic logic [31:0] next_rand(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   initial
   begin
      sys_clk15 = 1'b0;
      forever #2 sys_clk15 = ~sys_clk15;   // 4 ns period
   end

   smc_lite_top i_dut (
      .sys_clk15, .n_sys_reset15,
      .req_valid, .req_write, .req_addr, .req_wdata, .req_n_be, .req_wele, .req_ws,
      .credit_return, .rdata_valid, .rdata, .smc_busy,
      .smc_addr, .smc_wdata, .smc_n_cs, .smc_n_rd, .smc_n_we, .smc_n_wr,
      .smc_n_ext_oe, .smc_rdata
   );

   // --------------------
   // SRAM model
   // --------------------
   always @(posedge sys_clk15)
   begin
      if (!smc_n_cs && !smc_n_wr)
         for (int b = 0; b < smc_lite_pkg::SMC_BE_W; b++)
            if (!smc_n_we[b])
               sram[smc_addr][8*b +: 8] <= smc_wdata[8*b +: 8];   // Enabled lanes only
   end

   assign smc_rdata = (!smc_n_cs && !smc_n_rd) ? sram[smc_addr] : '0;

   task automatic load_golden();
      $readmemh("testbench/smc_lite_golden.txt", golden_mem);
      num_reads     = 0;
      timeout_limit = 20;
      for (int i = 0; i < NUM_ACC; i++)
      begin
         if ($isunknown(golden_mem[i*NUM_COL+6]))
            abort_run("Golden file holds fewer rows than expected");
         acc_write[i] = golden_mem[i*NUM_COL][0];
         acc_addr[i]  = golden_mem[i*NUM_COL+1][smc_lite_pkg::SMC_ADDR_W-1:0];
         acc_n_be[i]  = golden_mem[i*NUM_COL+2][smc_lite_pkg::SMC_BE_W-1:0];
         acc_wdata[i] = golden_mem[i*NUM_COL+3];
         acc_wele[i]  = golden_mem[i*NUM_COL+4][smc_lite_pkg::SMC_LE_W-1:0];
         acc_ws[i]    = golden_mem[i*NUM_COL+5][smc_lite_pkg::SMC_WS_W-1:0];
         acc_rdata[i] = golden_mem[i*NUM_COL+6];
         if (!acc_write[i])
            num_reads++;
         timeout_limit += 2 * (acc_wele[i] + acc_ws[i] + 6);   // Generous per access
      end
   endtask

   // --------------------
   // Host side
   // --------------------
   initial
   begin
      int unsigned gap;
      n_sys_reset15 = 1'b0;
      req_valid     = 1'b0;
      req_write     = 1'b0;
      req_addr      = '0;
      req_wdata     = '0;
      req_n_be      = '1;
      req_wele      = '0;
      req_ws        = '0;
      credits       = DEPTH;
      {issued, accepted, started, mon_idx, ret_idx} = '0;
      {reads_done, cycle_count} = '0;
      prev_cs       = 1'b1;
      expect_chain  = 1'b0;
      lead_cnt      = '0;
      strobe_cnt    = '0;
      rand_state    = 32'h6f8b;
      foreach (sram[a])
         sram[a] = '0;
      load_golden();
      repeat (5) @(posedge sys_clk15);
      n_sys_reset15 <= 1'b1;
      repeat (2) @(posedge sys_clk15);   // Quiet cycles out of reset
      for (int i = 0; i < NUM_ACC; i++)
      begin
         rand_state = next_rand(rand_state);
         gap        = rand_state[31:30];
         if (gap != 0)
         begin
            req_valid <= 1'b0;
            repeat (gap) @(posedge sys_clk15);
         end
         while (credits == 0)
         begin
            req_valid <= 1'b0;   // Stall, no credit
            @(posedge sys_clk15);
         end
         req_valid <= 1'b1;
         req_write <= acc_write[i];
         req_addr  <= acc_addr[i];
         req_wdata <= acc_wdata[i];
         req_n_be  <= acc_n_be[i];
         req_wele  <= acc_wele[i];
         req_ws    <= acc_ws[i];
         credits   = credits - 1;
         issued    = issued + 1;
         @(posedge sys_clk15);
      end
      req_valid <= 1'b0;
      while (ret_idx < NUM_ACC)
         @(posedge sys_clk15);
      repeat (2) @(negedge sys_clk15);
      check_level("smc_busy", smc_busy, 1'b0);
      check_level("smc_n_cs", smc_n_cs, 1'b1);
      check_count("host credits", credits, DEPTH);
      check_count("read returns", reads_done, num_reads);
      check_count("bus accesses", mon_idx, NUM_ACC);
      if (i_dut.i_assert.fail_count == 0)
      begin
         $display("TEST RESULT: PASS");
         $finish;
      end
      else
         abort_run("A concurrent assertion on the DUT failed");
   end

   always @(posedge sys_clk15)
   begin
      cycle_count++;
      if (cycle_count > timeout_limit)
         abort_run("Timeout, accesses did not finish within the cycle limit");
   end

   // --------------------
   // Monitors, mid-cycle
   // --------------------
   task automatic check_reset_values();
      check_level("smc_n_cs", smc_n_cs, 1'b1);
      check_level("smc_n_rd", smc_n_rd, 1'b1);
      check_level("smc_n_wr", smc_n_wr, 1'b1);
      check_level("smc_n_ext_oe", smc_n_ext_oe, 1'b1);
      check_be("smc_n_we", smc_n_we, '1);
      check_level("smc_busy", smc_busy, 1'b0);
      check_level("credit_return", credit_return, 1'b0);
      check_level("rdata_valid", rdata_valid, 1'b0);
   endtask

   // One cycle with chip select low
   task automatic watch_access();
      logic strobe;
      if (mon_idx >= NUM_ACC)
         abort_run("Chip select went low with no access outstanding");
      if (prev_cs)
      begin
         started++;   // Falling edge of chip select
         lead_cnt   = '0;
         strobe_cnt = '0;
      end
      strobe = acc_write[mon_idx] ? !smc_n_wr : !smc_n_rd;
      check_addr("smc_addr", smc_addr, acc_addr[mon_idx]);
      check_level("smc_busy", smc_busy, 1'b1);
      check_level("smc_n_ext_oe", smc_n_ext_oe, !acc_write[mon_idx]);   // Writes drive
      if (acc_write[mon_idx])
      begin
         check_data("smc_wdata", smc_wdata, acc_wdata[mon_idx]);
         check_level("smc_n_rd", smc_n_rd, 1'b1);
      end
      else
         check_level("smc_n_wr", smc_n_wr, 1'b1);
      if (strobe && acc_write[mon_idx])
         check_be("smc_n_we", smc_n_we, acc_n_be[mon_idx]);
      else
         check_be("smc_n_we", smc_n_we, '1);
      if (strobe)
         strobe_cnt = strobe_cnt + 1'b1;
      else if (strobe_cnt != 0)
         abort_run("Strobe went high again while chip select stayed low");
      else
         lead_cnt = lead_cnt + 1'b1;   // Still in LE
   endtask

   task automatic close_access();
      check_width("LE cycles", lead_cnt, acc_wele[mon_idx]);
      check_width("strobe cycles", strobe_cnt, {1'b0, acc_ws[mon_idx]} + 1'b1);
      mon_idx++;
   endtask

   // FLOAT cycle of a completed access
   task automatic watch_return();
      if (ret_idx >= NUM_ACC)
         abort_run("credit_return pulsed with no access outstanding");
      check_level("smc_busy", smc_busy, 1'b1);
      check_level("rdata_valid", rdata_valid, !acc_write[ret_idx]);
      if (!acc_write[ret_idx])
      begin
         check_data("rdata", rdata, acc_rdata[ret_idx]);
         reads_done++;
      end
      ret_idx++;
      credits++;
      if (accepted > started)
         expect_chain = 1'b1;   // Next access already queued
   endtask

   always @(negedge sys_clk15)
   begin
      if (i_dut.i_assert.fail_count != 0)
         abort_run("A concurrent assertion on the DUT failed");
      if (issued == 0)
         check_reset_values();
      if (expect_chain)
         check_level("smc_n_cs after FLOAT", smc_n_cs, 1'b0);
      expect_chain = 1'b0;
      if (!smc_n_cs)
         watch_access();
      else
      begin
         if (!prev_cs)
            close_access();
         check_level("smc_n_rd", smc_n_rd, 1'b1);
         check_level("smc_n_wr", smc_n_wr, 1'b1);
         check_level("smc_n_ext_oe", smc_n_ext_oe, 1'b1);
         check_be("smc_n_we", smc_n_we, '1);
         if (!credit_return)
            check_level("smc_busy", smc_busy, 1'b0);   // Neither LE, RW nor FLOAT
      end
      if (credit_return)
         watch_return();
      else
         check_level("rdata_valid", rdata_valid, 1'b0);
      if (credits < 0 || credits > DEPTH)
         abort_run("Host credit count left the range 0 to queue depth");
      if (n_sys_reset15 && req_valid)
         accepted++;   // Taken at the coming edge
      prev_cs = smc_n_cs;
   end

endmodule

//--- testbench/smc_lite_golden.txt
// Columns: write addr n_be wdata wele ws expected_rdata (all hex)
// Expected rdata is the byte-merged SRAM word, zero for writes
1 0010 0 11223344 0 00 00000000
0 0010 f 00000000 0 00 11223344
1 0010 c aabbccdd 1 02 00000000
0 0010 f 00000000 2 01 1122ccdd
1 0020 0 deadbeef 3 00 00000000
1 0020 5 01234567 0 03 00000000
0 0020 f 00000000 3 04 01ad45ef
0 0030 f 00000000 1 00 00000000
1 0030 e 0000005a 2 01 00000000
1 0030 b 00990000 0 00 00000000
0 0030 f 00000000 0 02 0099005a
1 ffff 0 cafef00d 1 05 00000000
0 ffff f 00000000 1 10 cafef00d
0 0010 f 00000000 0 00 1122ccdd
1 0020 f 77777777 0 01 00000000
0 0020 0 00000000 0 00 01ad45ef

//--- sim.f
+incdir+testbench
hw/smc_lite_pkg.sv
hw/smc_access_queue.sv
hw/smc_phase_ctrl.sv
hw/smc_edge_timer.sv
hw/smc_ext_bus.sv
hw/smc_read_return.sv
hw/smc_lite_top.sv
testbench/smc_lite_assert.sv
testbench/smc_lite_tb.sv

//--- Bender.yml
package:
  name: smc_lite

sources:
  # RTL, package first
  - files:
      - hw/smc_lite_pkg.sv
      - hw/smc_access_queue.sv
      - hw/smc_phase_ctrl.sv
      - hw/smc_edge_timer.sv
      - hw/smc_ext_bus.sv
      - hw/smc_read_return.sv
      - hw/smc_lite_top.sv
  # Testbench with bound assertions
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/smc_lite_assert.sv
      - testbench/smc_lite_tb.sv
